// File: common/lsu_pkg.sv
// ========================================================================
// lsu address package
// shared address, operation and size types for the load/store address path
// ========================================================================

package lsu_pkg;

	// ====================================================================
	// widths
	// ====================================================================

	// byte address width, virtual and physical alike
	localparam int ADDR_BITS = 32;

	// log2 of the cache line size (64 bytes)
	localparam int LINE_BITS = 6;
	localparam int LINE_BYTES = 1 << LINE_BITS;

	// log2 of the page size (4 KiB)
	localparam int PAGE_BITS = 12;

	// physical page number width, what remains above the page offset
	localparam int PPN_BITS = ADDR_BITS - PAGE_BITS;

	// page table index, 16 entries
	localparam int MAP_IDX_BITS = 4;

	// signed displacement field of the indexed form
	localparam int DISP_BITS = 12;

	// ====================================================================
	// types
	// ====================================================================

	typedef logic [ADDR_BITS-1:0] addr_t;

	// operation kind
	// code 3 is unused and yields a zero address
	typedef enum logic [1:0]
	{
		OPK_LS  = 2'd0,	// load/store, base plus immediate
		OPK_LSX = 2'd1,	// indexed, scaled register plus displacement
		OPK_AMO = 2'd2	// atomic, base plus register
	} op_kind_t;

	// log2 of access bytes
	// 0..4 -> 1, 2, 4, 8, 16 bytes
	typedef logic [2:0] size_t;

	// memory operation as it arrives, fields already split out
	typedef struct packed
	{
		op_kind_t              kind;
		size_t                 size;
		logic                  vec;		// vector element access
		logic                  unpacked;	// lane selects element, else elem
		logic [2:0]            lane;
		logic [2:0]            elem;
		logic [1:0]            sc;		// index shift for OPK_LSX
		logic [DISP_BITS-1:0]  disp;		// signed
	} mem_op_t;

endpackage

// File: common/agen_if.sv
// ========================================================================
// agen interface
// pass start, result and translation strobes between sequencer, agen, timer
// ========================================================================

`timescale 1ns/10ps

interface agen_if import lsu_pkg::*; ();

	// one cycle pulse that starts an address pass
	logic  out;
	// level, select next line mode for the running pass
	logic  next;
	// registered virtual address
	addr_t res;
	// sticky result valid
	logic  resv;
	// translation done pulse
	logic  tlb_v;

	// sequencer side
	modport seq (output out, output next, input res, input resv, input tlb_v);

	// address generator side
	modport gen (input out, input next, input tlb_v, output res, output resv);

	// translation timer side
	modport tmr (input resv, output tlb_v);

endinterface

// File: hw/agen/agen.sv
// ========================================================================
// effective address generator
// base, vector element offset and kind specific term, registered result
// with a sticky valid that translation done clears
// ========================================================================

`timescale 1ns/10ps

module agen import lsu_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  mem_op_t op,
	input  addr_t   a,
	input  addr_t   b,
	input  addr_t   i,
	agen_if.gen     ag
);

	// element index picked by the packing mode
	logic [2:0] elem_idx;
	// element byte offset, index scaled by access size
	addr_t      elem_ofs;
	// base after vector adjustment
	addr_t      as;
	// scaled index register
	addr_t      bs;
	// sign extended displacement
	addr_t      disp_ext;
	// unregistered effective address
	addr_t      res1;
	// first stage of the sticky valid
	logic       resv1;

	// ====================================================================
	// base formation
	// ====================================================================

	// unpacked vectors address by lane, packed ones by element number
	always_comb
	begin
		elem_idx = op.unpacked ? op.lane : op.elem;
		elem_ofs = addr_t'(elem_idx) << op.size;
	end

	// scalar accesses use a as is
	always_comb
	begin
		if (op.vec)
			as = a + elem_ofs;
		else
			as = a;
	end

	// ====================================================================
	// kind specific offset
	// ====================================================================

	always_comb
	begin
		bs = b << op.sc;
		disp_ext = {{(ADDR_BITS-DISP_BITS){op.disp[DISP_BITS-1]}}, op.disp};
	end

	always_comb
	begin
		case (op.kind)
			OPK_LS:
				res1 = as + i;
			OPK_LSX:
				res1 = as + bs + disp_ext;
			OPK_AMO:
				res1 = as + b;
			default:
				res1 = '0;
		endcase
	end

	// result register, loaded every cycle
	// next mode steps to the start of the following line
	always_ff @(posedge clk)
	begin
		if (ag.next)
			ag.res <= {res1[ADDR_BITS-1:LINE_BITS] + 1'b1, {LINE_BITS{1'b0}}};
		else
			ag.res <= res1;
	end

	// ====================================================================
	// sticky valid
	// ====================================================================

	// res lands one cycle after out, so the valid trails by one more stage
	// translation done drops both stages at once
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			resv1   <= 1'b0;
			ag.resv <= 1'b0;
		end
		else if (ag.tlb_v)
		begin
			resv1   <= 1'b0;
			ag.resv <= 1'b0;
		end
		else
		begin
			if (ag.out)
				resv1 <= 1'b1;
			ag.resv <= resv1;
		end
	end

endmodule

// File: hw/addr_seq/addr_seq.sv
// ========================================================================
// address sequencer
// captures one operation, runs one or two agen passes, detects line split
// ========================================================================

`timescale 1ns/10ps

module addr_seq import lsu_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    issue,
	input  mem_op_t op_in,
	input  addr_t   a_in,
	input  addr_t   b_in,
	input  addr_t   i_in,
	agen_if.seq     ag,
	output mem_op_t op,
	output addr_t   a,
	output addr_t   b,
	output addr_t   i,
	output logic    busy,
	output logic    line2
);

	typedef enum logic [2:0]
	{
		IDLE  = 3'd0,
		GEN1  = 3'd1,	// first pass start
		WAIT1 = 3'd2,	// first pass translating
		GEN2  = 3'd3,	// second pass start, next line
		WAIT2 = 3'd4,	// second pass translating
		DONE  = 3'd5	// last request leaves this cycle
	} state_t;

	state_t state;

	// byte count of the access
	logic [LINE_BITS:0] acc_bytes;
	// one past the last byte, as a line offset
	logic [LINE_BITS:0] line_end;
	logic               crosses;

	// ====================================================================
	// line crossing
	// ====================================================================

	// res holds the first pass address while WAIT1 sees tlb_v
	always_comb
	begin
		acc_bytes = (LINE_BITS+1)'(1) << op.size;
		line_end  = {1'b0, ag.res[LINE_BITS-1:0]} + acc_bytes;
		crosses   = line_end > (LINE_BITS+1)'(LINE_BYTES);
	end

	// ====================================================================
	// state machine
	// ====================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE:
					if (issue)
						state <= GEN1;
				GEN1:
					state <= WAIT1;
				WAIT1:
					if (ag.tlb_v)
						state <= crosses ? GEN2 : DONE;
				GEN2:
					state <= WAIT2;
				WAIT2:
					if (ag.tlb_v)
						state <= DONE;
				DONE:
					state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	// operands are held for the whole operation
	// issue while busy never reaches here
	always_ff @(posedge clk)
	begin
		if (state == IDLE && issue)
		begin
			op <= op_in;
			a  <= a_in;
			b  <= b_in;
			i  <= i_in;
		end
	end

	// one out pulse per pass
	assign ag.out  = (state == GEN1) || (state == GEN2);
	// next held across the second pass so res stays on the next line
	assign ag.next = (state == GEN2) || (state == WAIT2);
	// tags the request that page_xlat captures on tlb_v
	assign line2   = ag.next;
	assign busy    = (state != IDLE);

endmodule

// File: hw/xlat_timer.sv
// ========================================================================
// translation timer
// fixed latency stand in for the TLB, pulses tlb_v after XLAT_LAT cycles
// ========================================================================

`timescale 1ns/10ps

module xlat_timer #(
	parameter int XLAT_LAT = 3
) (
	input  logic clk,
	input  logic rst,
	agen_if.tmr  tm
);

	// remaining cycles, zero when idle
	logic [3:0] cnt;
	// resv one cycle late, for edge detect
	logic       resv_d;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt    <= 4'd0;
			resv_d <= 1'b0;
		end
		else
		begin
			resv_d <= tm.resv;
			// start on the rising edge of the agen valid
			if (tm.resv && !resv_d)
				cnt <= 4'(XLAT_LAT);
			else if (cnt != 4'd0)
				cnt <= cnt - 4'd1;
		end
	end

	// last count is the done cycle, resv is still high here
	assign tm.tlb_v = (cnt == 4'd1);

endmodule

// File: hw/page_xlat.sv
// ========================================================================
// page translation
// 16 entry page table, registers the physical request on translation done
// ========================================================================

`timescale 1ns/10ps

module page_xlat import lsu_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    map_we,
	input  logic [MAP_IDX_BITS-1:0] map_idx,
	input  logic [PPN_BITS-1:0]     map_base,
	input  addr_t                   vaddr,
	input  logic                    tlb_v,
	input  logic                    line2,
	output logic                    req_valid,
	output addr_t                   req_addr,
	output logic                    req_line2
);

	localparam int MAP_ENTRIES = 1 << MAP_IDX_BITS;

	// virtual page slot -> physical page number
	logic [PPN_BITS-1:0]     map [MAP_ENTRIES];
	// table slot from the low bits of the virtual page number
	logic [MAP_IDX_BITS-1:0] vidx;

	assign vidx = vaddr[PAGE_BITS +: MAP_IDX_BITS];

	// table is loaded between operations
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int k = 0; k < MAP_ENTRIES; k++)
				map[k] <= '0;
		end
		else if (map_we)
			map[map_idx] <= map_base;
	end

	// request strobe one cycle after translation done
	always_ff @(posedge clk)
	begin
		if (rst)
			req_valid <= 1'b0;
		else
			req_valid <= tlb_v;
	end

	// physical page joined with the untranslated page offset
	always_ff @(posedge clk)
	begin
		if (tlb_v)
		begin
			req_addr  <= {map[vidx], vaddr[PAGE_BITS-1:0]};
			req_line2 <= line2;
		end
	end

endmodule

// File: hw/lsu_addr_top.sv
// ========================================================================
// lsu address top
// sequencer, address generator, translation timer and page table
// ========================================================================

`timescale 1ns/10ps

module lsu_addr_top import lsu_pkg::*; #(
	parameter int XLAT_LAT = 3
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    issue,
	input  mem_op_t                 op,
	input  addr_t                   a,
	input  addr_t                   b,
	input  addr_t                   i,
	input  logic                    map_we,
	input  logic [MAP_IDX_BITS-1:0] map_idx,
	input  logic [PPN_BITS-1:0]     map_base,
	output logic                    busy,
	output logic                    req_valid,
	output logic                    req_line2,
	output addr_t                   req_addr
);

	// captured operation and operands
	mem_op_t seq_op;
	addr_t   seq_a;
	addr_t   seq_b;
	addr_t   seq_i;
	// which pass the current translation belongs to
	logic    line2;

	agen_if ag ();

	addr_seq u_seq (
		.clk   (clk),
		.rst   (rst),
		.issue (issue),
		.op_in (op),
		.a_in  (a),
		.b_in  (b),
		.i_in  (i),
		.ag    (ag.seq),
		.op    (seq_op),
		.a     (seq_a),
		.b     (seq_b),
		.i     (seq_i),
		.busy  (busy),
		.line2 (line2)
	);

	agen u_agen (
		.clk (clk),
		.rst (rst),
		.op  (seq_op),
		.a   (seq_a),
		.b   (seq_b),
		.i   (seq_i),
		.ag  (ag.gen)
	);

	xlat_timer #(
		.XLAT_LAT (XLAT_LAT)
	) u_tmr (
		.clk (clk),
		.rst (rst),
		.tm  (ag.tmr)
	);

	// page table sees the agen result and the timer strobe directly
	page_xlat u_xlat (
		.clk       (clk),
		.rst       (rst),
		.map_we    (map_we),
		.map_idx   (map_idx),
		.map_base  (map_base),
		.vaddr     (ag.res),
		.tlb_v     (ag.tlb_v),
		.line2     (line2),
		.req_valid (req_valid),
		.req_addr  (req_addr),
		.req_line2 (req_line2)
	);

endmodule

// File: verification/lsu_addr_asserts.sv
// ========================================================================
// lsu address assertions
// protocol rules on busy, request strobe and the translation handshake
// ========================================================================

`timescale 1ns/10ps

module lsu_addr_asserts (
	input  logic clk,
	input  logic rst,
	input  logic busy,
	input  logic req_valid,
	input  logic out,
	input  logic resv,
	input  logic tlb_v
);

	// assertion failures counted for the closing summary
	int fail_cnt = 0;

	// a request only leaves while an operation is running
	req_in_busy: assert property (@(posedge clk) disable iff (rst) req_valid |-> busy)
	else
	begin
		$error("req_valid high while busy is low");
		fail_cnt++;
	end

	// translation done needs a valid agen result behind it
	tlb_after_resv: assert property (@(posedge clk) disable iff (rst) $rose(tlb_v) |-> resv)
	else
	begin
		$error("tlb_v rose while resv was low");
		fail_cnt++;
	end

	// busy only drops in the cycle after a request
	busy_fall: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> $past(req_valid))
	else
	begin
		$error("busy fell without a request in the cycle before");
		fail_cnt++;
	end

	// a request with no second pass starting is the last one of the operation
	last_req: assert property (@(posedge clk) disable iff (rst)
		req_valid && !out |=> !busy)
	else
	begin
		$error("busy still high after the last request");
		fail_cnt++;
	end

endmodule

bind lsu_addr_top lsu_addr_asserts u_asserts (
	.clk       (clk),
	.rst       (rst),
	.busy      (busy),
	.req_valid (req_valid),
	.out       (ag.out),
	.resv      (ag.resv),
	.tlb_v     (ag.tlb_v)
);

// File: verification/lsu_addr_checker.sv
// ========================================================================
// lsu address checker
// compares each request of the DUT with the model queue, per test summary
// ========================================================================

`timescale 1ns/10ps

module lsu_addr_checker import lsu_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  busy,
	input  logic  req_valid,
	input  logic  req_line2,
	input  addr_t req_addr
);

	// expected requests, oldest first, line2 flag on top
	logic [ADDR_BITS:0] exp_q [$];

	int errors = 0;
	int test_errors = 0;
	int tests = 0;
	int failed_tests = 0;
	int checked = 0;

	function automatic void note_error();
		errors++;
		test_errors++;
	endfunction

	task automatic push_expected(input addr_t addr, input logic line2);
		exp_q.push_back({line2, addr});
	endtask

	// idle outputs, used around reset
	task automatic check_idle();
		if (busy !== 1'b0)
		begin
			$display("Error %0t busy: expected 0, got %b", $time, busy);
			note_error();
		end
		if (req_valid !== 1'b0)
		begin
			$display("Error %0t req_valid: expected 0, got %b", $time, req_valid);
			note_error();
		end
	endtask

	// outputs change on the rising edge, so mid cycle they are settled
	always @(negedge clk)
	begin
		logic [ADDR_BITS:0] want;
		if (!rst && req_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("request at %0t to %08h was not expected", $time, req_addr);
				note_error();
			end
			else
			begin
				want = exp_q.pop_front();
				checked++;
				if (req_addr !== want[ADDR_BITS-1:0])
				begin
					$display("Error %0t req_addr: expected %08h, got %08h",
						$time, want[ADDR_BITS-1:0], req_addr);
					note_error();
				end
				if (req_line2 !== want[ADDR_BITS])
				begin
					$display("Error %0t req_line2: expected %b, got %b",
						$time, want[ADDR_BITS], req_line2);
					note_error();
				end
			end
		end
	end

	// closes a test, anything still queued never showed up
	task automatic end_test(input string name);
		if (exp_q.size() != 0)
		begin
			$display("test %s ended with %0d expected requests missing", name, exp_q.size());
			note_error();
			exp_q.delete();
		end
		tests++;
		if (test_errors != 0)
			failed_tests++;
		$display("test %-12s %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed",
			test_errors);
		test_errors = 0;
	endtask

endmodule

// File: verification/tb_lsu_addr.sv
// ========================================================================
// lsu address testbench
// random operations from an xorshift source, model queue, watchdog
// ========================================================================

`timescale 1ns/10ps

module tb_lsu_addr import lsu_pkg::*; ();

	localparam int XLAT_LAT = 3;
	// operations over all tests, sizes the watchdog
	localparam int NUM_OPS = 120;
	localparam int WATCHDOG_CYCLES = NUM_OPS * (4 * XLAT_LAT + 10);

	logic                    clk;
	logic                    rst;
	logic                    issue;
	mem_op_t                 op;
	addr_t                   a;
	addr_t                   b;
	addr_t                   i;
	logic                    map_we;
	logic [MAP_IDX_BITS-1:0] map_idx;
	logic [PPN_BITS-1:0]     map_base;
	logic                    busy;
	logic                    req_valid;
	logic                    req_line2;
	addr_t                   req_addr;

	logic [31:0]             rng;
	// model copy of the page table
	logic [PPN_BITS-1:0]     map_model [1 << MAP_IDX_BITS];

	lsu_addr_top #(
		.XLAT_LAT (XLAT_LAT)
	) u_dut (
		.clk       (clk),
		.rst       (rst),
		.issue     (issue),
		.op        (op),
		.a         (a),
		.b         (b),
		.i         (i),
		.map_we    (map_we),
		.map_idx   (map_idx),
		.map_base  (map_base),
		.busy      (busy),
		.req_valid (req_valid),
		.req_line2 (req_line2),
		.req_addr  (req_addr)
	);

	lsu_addr_checker u_chk (
		.clk       (clk),
		.rst       (rst),
		.busy      (busy),
		.req_valid (req_valid),
		.req_line2 (req_line2),
		.req_addr  (req_addr)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// ====================================================================
	// random source and reference model
	// ====================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// virtual address straight from the operation rules
	function automatic addr_t model_vaddr(input mem_op_t o, input addr_t ra, input addr_t rb,
		input addr_t ri);
		addr_t idx;
		addr_t base;
		idx  = o.unpacked ? addr_t'(o.lane) : addr_t'(o.elem);
		base = o.vec ? ra + (idx << o.size) : ra;
		case (o.kind)
			OPK_LS:
				return base + ri;
			OPK_LSX:
				return base + (rb << o.sc) + addr_t'($signed(o.disp));
			OPK_AMO:
				return base + rb;
			default:
				return '0;
		endcase
	endfunction

	// page number from the model table, offset passes through
	function automatic addr_t translate(input addr_t va);
		return {map_model[va[PAGE_BITS +: MAP_IDX_BITS]], va[PAGE_BITS-1:0]};
	endfunction

	// ====================================================================
	// stimulus
	// ====================================================================

	task automatic write_map(input logic [MAP_IDX_BITS-1:0] idx, input logic [PPN_BITS-1:0] pg);
		@(negedge clk);
		map_we   = 1'b1;
		map_idx  = idx;
		map_base = pg;
		@(negedge clk);
		map_we = 1'b0;
		map_model[idx] = pg;
	endtask

	// mode 1 puts the access near a line end, mode 2 near a page end
	// poke sends a second issue while busy, which must be dropped
	task automatic run_op(input op_kind_t kind, input size_t size, input logic vec,
		input int mode, input logic poke);
		mem_op_t              o;
		addr_t                ra;
		addr_t                rb;
		addr_t                ri;
		addr_t                va;
		addr_t                va2;
		addr_t                delta;
		logic [31:0]          r;
		logic [LINE_BITS-1:0] ofs;
		logic [PAGE_BITS-1:0] want;
		int                   bytes;
		r = next_rand();
		o.kind     = kind;
		o.size     = size;
		o.vec      = vec;
		o.unpacked = r[0];
		o.lane     = r[3:1];
		o.elem     = r[6:4];
		o.sc       = r[8:7];
		o.disp     = r[20:9];
		ra = next_rand();
		rb = next_rand();
		ri = next_rand();
		bytes = 1 << size;
		va = model_vaddr(o, ra, rb, ri);
		if (mode != 0)
		begin
			r   = next_rand();
			ofs = LINE_BITS'(LINE_BYTES - 1 - (int'(r[7:0]) % bytes));
			if (mode == 2)
				want = {{(PAGE_BITS-LINE_BITS){1'b1}}, ofs};
			else
				want = {va[PAGE_BITS-1:LINE_BITS], ofs};
			delta = addr_t'(want) - addr_t'(va[PAGE_BITS-1:0]);
			ra = ra + delta;
			va = va + delta;
		end
		u_chk.push_expected(translate(va), 1'b0);
		// second request starts on the next line
		if (int'(va[LINE_BITS-1:0]) + bytes > LINE_BYTES)
		begin
			va2 = (va & ~addr_t'(LINE_BYTES - 1)) + addr_t'(LINE_BYTES);
			u_chk.push_expected(translate(va2), 1'b1);
		end
		@(negedge clk);
		op    = o;
		a     = ra;
		b     = rb;
		i     = ri;
		issue = 1'b1;
		@(negedge clk);
		issue = 1'b0;
		if (poke)
		begin
			@(negedge clk);
			a     = ~ra;
			issue = 1'b1;
			@(negedge clk);
			issue = 1'b0;
		end
		while (busy)
			@(negedge clk);
	endtask

	// ====================================================================
	// test sequence
	// ====================================================================

	initial
	begin
		logic [31:0] r;
		int          k;
		int          s;
		int          total;
		rng      = 32'd50283;
		rst      = 1'b1;
		issue    = 1'b0;
		op       = '0;
		a        = '0;
		b        = '0;
		i        = '0;
		map_we   = 1'b0;
		map_idx  = '0;
		map_base = '0;
		for (k = 0; k < (1 << MAP_IDX_BITS); k++)
			map_model[k] = '0;
		repeat (3)
			@(negedge clk);
		u_chk.check_idle();
		rst = 1'b0;
		@(negedge clk);
		u_chk.check_idle();
		u_chk.end_test("reset_idle");

		for (k = 0; k < (1 << MAP_IDX_BITS); k++)
		begin
			r = next_rand();
			write_map(MAP_IDX_BITS'(k), r[PPN_BITS-1:0]);
		end

		for (k = 0; k < 20; k++)
		begin
			r = next_rand();
			run_op(OPK_LS, size_t'(r % 5), 1'b0, 0, 1'b0);
		end
		u_chk.end_test("scalar_imm");

		for (k = 0; k < 20; k++)
		begin
			r = next_rand();
			run_op((k % 2 != 0) ? OPK_AMO : OPK_LSX, size_t'(r % 5), 1'b0, 0, 1'b0);
		end
		u_chk.end_test("idx_amo");

		// every access size with element offsets
		for (s = 0; s < 5; s++)
		begin
			for (k = 0; k < 5; k++)
			begin
				r = next_rand();
				run_op(op_kind_t'(2'(r % 3)), size_t'(s), 1'b1, 0, 1'b0);
			end
		end
		u_chk.end_test("vector");

		for (k = 0; k < 30; k++)
		begin
			r = next_rand();
			run_op(op_kind_t'(2'(r % 3)), size_t'(r[15:8] % 5), r[20], 1, 1'b0);
		end
		u_chk.end_test("line_cross");

		// table rewrites between operations, splits across pages
		for (k = 0; k < 20; k++)
		begin
			r = next_rand();
			write_map(r[3:0], r[31:12]);
			r = next_rand();
			run_op(op_kind_t'(2'(r % 3)), size_t'(r[15:8] % 5), r[20], 2, 1'b0);
		end
		u_chk.end_test("page_map");

		for (k = 0; k < 5; k++)
		begin
			r = next_rand();
			run_op(op_kind_t'(2'(r % 3)), size_t'(r[15:8] % 5), 1'b0, 0, 1'b1);
		end
		u_chk.end_test("issue_busy");

		total = u_chk.errors + u_dut.u_asserts.fail_cnt;
		$display("tests %0d, failed %0d, requests checked %0d, errors %0d, assertion failures %0d",
			u_chk.tests, u_chk.failed_tests, u_chk.checked, u_chk.errors,
			u_dut.u_asserts.fail_cnt);
		if (total == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// ends a hung run
	initial
	begin
		repeat (WATCHDOG_CYCLES)
			@(posedge clk);
		$display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: sources.f
common/lsu_pkg.sv
common/agen_if.sv
hw/agen/agen.sv
hw/addr_seq/addr_seq.sv
hw/xlat_timer.sv
hw/page_xlat.sv
hw/lsu_addr_top.sv
verification/lsu_addr_asserts.sv
verification/lsu_addr_checker.sv
verification/tb_lsu_addr.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_lsu_addr
FILELIST  = sources.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
RUN_ARGS  = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
